// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fb_bounce_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q '^TESTBENCH PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/fb_bounce_assert.sv ====
// fb arbiter assertions
// grant exclusivity and read timing checks on the arbiter
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter_assert (
    input wire logic clk_100m,
    input wire logic rst_n,
    input wire logic rd_en,
    input wire logic clr_gnt,
    input wire logic fill_gnt,
    input wire logic rd_valid
);

    // a read is a grant of its own
    a_one_grant: assert property (@(posedge clk_100m) disable iff (!rst_n)
        $onehot0({rd_en, clr_gnt, fill_gnt}))
        else $error("more than one framebuffer grant in a cycle");

    a_rd_valid_after_rd: assert property (@(posedge clk_100m) disable iff (!rst_n)
        rd_en |=> rd_valid)
        else $error("rd_valid missing one cycle after rd_en");

    a_rd_valid_only_after_rd: assert property (@(posedge clk_100m) disable iff (!rst_n)
        !rd_en |=> !rd_valid)
        else $error("rd_valid without a read one cycle earlier");

    a_no_write_on_read: assert property (@(posedge clk_100m) disable iff (!rst_n)
        rd_en |-> !(clr_gnt || fill_gnt))
        else $error("write granted while a read is pending");

endmodule

bind fb_arbiter fb_arbiter_assert fb_arbiter_assert_i (
    .clk_100m, .rst_n, .rd_en, .clr_gnt, .fill_gnt, .rd_valid
);

`default_nettype wire

// ==== sim/fb_bounce_tb.sv ====
// fb bounce testbench
// table-driven frame strobes checked against a bounce model and framebuffer probes
`timescale 1ns/1ps
`default_nettype none

`include "fb_bounce_consts.svh"

module fb_bounce_tb;

    localparam int n_stim = 8;
    localparam int busy_limit = 20000;  // cycles for a draw under read traffic

    typedef struct packed {
        logic [7:0] frames;   // strobes in this entry with the first starting the draw
        logic       rd_draw;  // read traffic while busy
        logic [7:0] px;       // probe pixel
        logic [7:0] py;
    } stim_t;

    stim_t stim_tbl [n_stim] = '{
        '{8'd1, 1'b0, 8'd4, 8'd4},    '{8'd1, 1'b1, 8'd0, 8'd0},
        '{8'd20, 1'b0, 8'd10, 8'd10}, '{8'd8, 1'b1, 8'd28, 8'd20},
        '{8'd12, 1'b0, 8'd30, 8'd12}, '{8'd1, 1'b1, 8'd16, 8'd8},
        '{8'd5, 1'b0, 8'd5, 8'd5},    '{8'd1, 1'b1, 8'd1, 8'd1}
    };

    logic clk_100m = 1'b0;
    logic rst_n, frame, rd_en, rd_valid, busy;
    fb_bounce_pkg::coord_t  rd_x, rd_y;
    fb_bounce_pkg::cidx_t   rd_cidx;
    fb_bounce_pkg::sq_pos_t sq_pos;
    int  mx, my, draw_x, draw_y, prev_x, prev_y;  // model position and drawn corners
    bit  mdx, mdy;
    logic [31:0] lcg_state = 32'h3270;
    int  mismatch_count = 0;
    int  fault_count = 0;

    fb_bounce_top fb_bounce_top_i (
        .clk_100m, .rst_n, .frame, .rd_en, .rd_x, .rd_y,
        .rd_cidx, .rd_valid, .sq_pos, .busy
    );

    always #5 clk_100m = ~clk_100m;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic model_step();
        if (mx >= `FB_WIDTH - (`SQ_SIZE + `SQ_SPEED)) begin
            mdx = 1'b1;
            mx  = mx - `SQ_SPEED;
        end else if (mx < `SQ_SPEED) begin
            mdx = 1'b0;
            mx  = mx + `SQ_SPEED;
        end else begin
            mx = mdx ? mx - `SQ_SPEED : mx + `SQ_SPEED;
        end
        if (my >= `FB_HEIGHT - (`SQ_SIZE + `SQ_SPEED)) begin
            mdy = 1'b1;
            my  = my - `SQ_SPEED;
        end else if (my < `SQ_SPEED) begin
            mdy = 1'b0;
            my  = my + `SQ_SPEED;
        end else begin
            my = mdy ? my - `SQ_SPEED : my + `SQ_SPEED;
        end
    endtask

    function automatic fb_bounce_pkg::sq_pos_t model_pos();
        fb_bounce_pkg::sq_pos_t p;
        p.x  = fb_bounce_pkg::coord_t'(mx);
        p.y  = fb_bounce_pkg::coord_t'(my);
        p.dx = mdx;
        p.dy = mdy;
        return p;
    endfunction

    function automatic fb_bounce_pkg::cidx_t expected_cidx(input int px, py, sx, sy);
        if (px >= sx && px < sx + `SQ_SIZE && py >= sy && py < sy + `SQ_SIZE)
            return fb_bounce_pkg::cidx_t'(`FB_FG_IDX);
        return fb_bounce_pkg::cidx_t'(`FB_BG_IDX);
    endfunction

    function automatic string pos_text(input fb_bounce_pkg::sq_pos_t p);
        return $sformatf("x=%0d y=%0d dx=%0d dy=%0d", p.x, p.y, p.dx, p.dy);
    endfunction

    task automatic check_pos(input string name, input fb_bounce_pkg::sq_pos_t exp, act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %s, actual %s", name, pos_text(exp), pos_text(act));
        end
    endtask

    task automatic check_cidx(input string name, input fb_bounce_pkg::cidx_t exp, act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic pulse_frame(input string name);
        @(negedge clk_100m);
        frame = 1'b1;
        @(negedge clk_100m);
        frame = 1'b0;
        model_step();
        check_pos(name, model_pos(), sq_pos);  // moved on the edge after the strobe
    endtask

    task automatic read_pixel(input int px, py, output fb_bounce_pkg::cidx_t data,
                              output bit ok);
        int cnt;
        @(negedge clk_100m);
        rd_en = 1'b1;
        rd_x  = fb_bounce_pkg::coord_t'(px);
        rd_y  = fb_bounce_pkg::coord_t'(py);
        @(negedge clk_100m);
        rd_en = 1'b0;
        cnt = 0;
        while (!rd_valid && cnt < 4) begin
            @(negedge clk_100m);
            cnt++;
        end
        ok   = rd_valid;
        data = rd_cidx;
        if (!ok) begin
            fault_count++;
            $display("timeout waiting for rd_valid on pixel (%0d,%0d)", px, py);
        end else if (cnt != 0) begin
            fault_count++;
            $display("rd_valid came %0d cycles late on pixel (%0d,%0d)", cnt, px, py);
        end
    endtask

    task automatic probe_pixel(input string name, input int px, py);
        fb_bounce_pkg::cidx_t data;
        bit ok;
        read_pixel(px, py, data, ok);
        if (ok) check_cidx($sformatf("%s (%0d,%0d)", name, px, py),
                           expected_cidx(px, py, draw_x, draw_y), data);
    endtask

    task automatic random_probe(input string name, input bit check);
        fb_bounce_pkg::cidx_t data;
        bit ok;
        int px, py;
        lcg_state = lcg_next(lcg_state);
        px = int'(lcg_state[15:8]) % `FB_WIDTH;
        py = int'(lcg_state[23:16]) % `FB_HEIGHT;
        if (check) probe_pixel(name, px, py);
        else read_pixel(px, py, data, ok);  // mid-draw data is not predicted
    endtask

    task automatic wait_busy(input bit level, input bit reads, input int limit);
        int cnt;
        cnt = 0;
        while (busy !== level && cnt < limit) begin
            if (reads) random_probe("draw read", 1'b0);
            else @(negedge clk_100m);
            cnt++;
        end
        if (busy !== level) begin
            fault_count++;
            $display("timeout waiting for busy to become %0d", level);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        frame = 1'b0;
        rd_en = 1'b0;
        rd_x  = '0;
        rd_y  = '0;
        {mx, my, mdx, mdy, draw_x, draw_y} = '0;
        repeat (2) @(negedge clk_100m);
        rst_n = 1'b1;
        if (busy !== 1'b0) begin
            fault_count++;
            $display("busy is not low after reset");
        end
        check_pos("reset", model_pos(), sq_pos);
        for (int i = 0; i < n_stim; i++) begin
            prev_x = draw_x;
            prev_y = draw_y;
            pulse_frame($sformatf("entry %0d frame 0", i));
            draw_x = mx;  // the draw takes the position after its own strobe
            draw_y = my;
            wait_busy(1'b1, 1'b0, 20);
            for (int f = 1; f < int'(stim_tbl[i].frames); f++)
                pulse_frame($sformatf("entry %0d frame %0d", i, f));
            wait_busy(1'b0, stim_tbl[i].rd_draw, busy_limit);
            probe_pixel("probe", int'(stim_tbl[i].px), int'(stim_tbl[i].py));
            probe_pixel("old corner", prev_x, prev_y);
            probe_pixel("moved corner", mx, my);
            probe_pixel("far corner", draw_x + `SQ_SIZE - 1, draw_y + `SQ_SIZE - 1);
            repeat (6) random_probe("random", 1'b1);
            if (stim_tbl[i].rd_draw) begin  // whole image after stalled writers
                for (int y = 0; y < `FB_HEIGHT; y++)
                    for (int x = 0; x < `FB_WIDTH; x++)
                        probe_pixel("sweep", x, y);
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/fb_bounce_pkg.sv
verilog/square_animator.sv
verilog/draw_sequencer.sv
verilog/fb_clearer.sv
verilog/rect_fill_drawer.sv
verilog/fb_arbiter.sv
verilog/fb_memory.sv
verilog/fb_bounce_top.sv
sim/fb_bounce_assert.sv
sim/fb_bounce_tb.sv

// ==== verilog/draw_sequencer.sv ====
// draw sequencer
// per frame clears the buffer, then fills the square at its new position
`timescale 1ns/1ps
`default_nettype none

`include "fb_bounce_consts.svh"

module draw_sequencer (
    input  wire logic                   clk_100m,
    input  wire logic                   rst_n,
    input  wire logic                   frame,
    input  wire fb_bounce_pkg::sq_pos_t sq_pos,
    output logic                        clear_start,
    output logic                        fill_start,
    input  wire logic                   clear_done,
    input  wire logic                   fill_done,
    output fb_bounce_pkg::rect_t        fill_rect,
    output logic                        busy
);

    localparam fb_bounce_pkg::coord_t sq_size = fb_bounce_pkg::coord_t'(`SQ_SIZE);

    fb_bounce_pkg::draw_state_t state;
    logic frame_q;  // frame delayed so the animator has moved

    assign busy = (state != fb_bounce_pkg::IDLE);

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state       <= fb_bounce_pkg::IDLE;
            frame_q     <= 1'b0;
            clear_start <= 1'b0;
            fill_start  <= 1'b0;
        end else begin
            frame_q     <= frame && !busy;  // frames during a draw are dropped here
            clear_start <= 1'b0;
            fill_start  <= 1'b0;
            case (state)
                fb_bounce_pkg::IDLE: if (frame_q) begin
                    clear_start <= 1'b1;
                    state       <= fb_bounce_pkg::CLEAR;
                end
                fb_bounce_pkg::CLEAR: if (clear_done) begin
                    fill_start <= 1'b1;
                    state      <= fb_bounce_pkg::FILL;
                end
                fb_bounce_pkg::FILL: if (fill_done) state <= fb_bounce_pkg::IDLE;
                default: state <= fb_bounce_pkg::IDLE;
            endcase
        end
    end

    // square outline taken from the updated position
    always_ff @(posedge clk_100m) begin
        if (state == fb_bounce_pkg::IDLE && frame_q) begin
            fill_rect.x0 <= sq_pos.x;
            fill_rect.y0 <= sq_pos.y;
            fill_rect.x1 <= sq_pos.x + sq_size;
            fill_rect.y1 <= sq_pos.y + sq_size;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fb_arbiter.sv ====
// framebuffer port arbiter
// fixed priority: scan-out read, then clear, then fill
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
    input  wire logic                   clk_100m,
    input  wire logic                   rst_n,
    input  wire logic                   rd_en,
    input  wire fb_bounce_pkg::coord_t  rd_x,
    input  wire fb_bounce_pkg::coord_t  rd_y,
    input  wire logic                   clr_req,
    input  wire fb_bounce_pkg::fb_req_t clr_wr,
    input  wire logic                   fill_req,
    input  wire fb_bounce_pkg::fb_req_t fill_wr,
    output logic                        clr_gnt,
    output logic                        fill_gnt,
    output fb_bounce_pkg::fb_req_t      mem_req,
    output logic                        rd_valid
);

    fb_bounce_pkg::arb_src_t src;
    fb_bounce_pkg::fb_req_t  rd_req;

    assign rd_req = '{we: 1'b0, x: rd_x, y: rd_y, cidx: '0};

    always_comb begin
        if (rd_en)         src = fb_bounce_pkg::SRC_READ;   // reads never wait
        else if (clr_req)  src = fb_bounce_pkg::SRC_CLEAR;
        else if (fill_req) src = fb_bounce_pkg::SRC_FILL;
        else               src = fb_bounce_pkg::SRC_NONE;
    end

    assign clr_gnt  = (src == fb_bounce_pkg::SRC_CLEAR);
    assign fill_gnt = (src == fb_bounce_pkg::SRC_FILL);

    always_comb begin
        case (src)
            fb_bounce_pkg::SRC_READ:  mem_req = rd_req;
            fb_bounce_pkg::SRC_CLEAR: mem_req = clr_wr;
            fb_bounce_pkg::SRC_FILL:  mem_req = fill_wr;
            default:                  mem_req = '0;  // idle read of pixel 0
        endcase
    end

    // memory read data appears one cycle after the read grant
    always_ff @(posedge clk_100m) begin
        if (!rst_n) rd_valid <= 1'b0;
        else        rd_valid <= (src == fb_bounce_pkg::SRC_READ);
    end

endmodule

`default_nettype wire

// ==== verilog/fb_bounce_consts.svh ====
// fb bounce constants
// framebuffer geometry, colour indices and square motion
`ifndef FB_BOUNCE_CONSTS_SVH
`define FB_BOUNCE_CONSTS_SVH

// framebuffer size in pixels
`define FB_WIDTH   32
`define FB_HEIGHT  24

// bus widths
`define FB_CORDW   8     // coordinate bits
`define FB_CIDXW   4     // colour index bits

// bouncing square
`define SQ_SIZE    8     // side length
`define SQ_SPEED   1     // pixels per frame

// colour indices
`define FB_BG_IDX  0     // background
`define FB_FG_IDX  11    // square colour

`endif

// ==== verilog/fb_bounce_pkg.sv ====
// fb bounce package
// shared coordinate, request and state types for the bounce subsystem
`default_nettype none

`include "fb_bounce_consts.svh"

package fb_bounce_pkg;

    typedef logic [`FB_CORDW-1:0] coord_t;  // unsigned pixel coordinate
    typedef logic [`FB_CIDXW-1:0] cidx_t;   // palette index

    typedef struct packed {
        logic   we;    // 1 writes, 0 reads
        coord_t x;
        coord_t y;
        cidx_t  cidx;  // write data unused on reads
    } fb_req_t;

    typedef struct packed {
        coord_t x;     // top-left corner
        coord_t y;
        logic   dx;    // 0 moves right
        logic   dy;    // 0 moves down
    } sq_pos_t;

    // fill covers x0..x1-1 and y0..y1-1
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
    } rect_t;

    typedef enum logic [1:0] {IDLE, CLEAR, FILL} draw_state_t;

    typedef enum logic [1:0] {SRC_NONE, SRC_READ, SRC_CLEAR, SRC_FILL} arb_src_t;

endpackage

`default_nettype wire

// ==== verilog/fb_bounce_top.sv ====
// fb bounce top level
// animator and draw sequencer feeding a shared framebuffer with a read port
`timescale 1ns/1ps
`default_nettype none

module fb_bounce_top (
    input  wire logic                  clk_100m,
    input  wire logic                  rst_n,
    input  wire logic                  frame,    // frame strobe
    input  wire logic                  rd_en,    // scan-out read request
    input  wire fb_bounce_pkg::coord_t rd_x,
    input  wire fb_bounce_pkg::coord_t rd_y,
    output fb_bounce_pkg::cidx_t       rd_cidx,
    output logic                       rd_valid,
    output fb_bounce_pkg::sq_pos_t     sq_pos,
    output logic                       busy
);

    logic clear_start, clear_done, fill_start, fill_done;
    logic clr_req, clr_gnt, fill_req, fill_gnt;
    fb_bounce_pkg::rect_t   fill_rect;
    fb_bounce_pkg::fb_req_t clr_wr, fill_wr, mem_req;

    square_animator square_animator_i (
        .clk_100m, .rst_n, .frame, .sq_pos
    );

    draw_sequencer draw_sequencer_i (
        .clk_100m, .rst_n, .frame, .sq_pos,
        .clear_start, .fill_start, .clear_done, .fill_done,
        .fill_rect, .busy
    );

    fb_clearer fb_clearer_i (
        .clk_100m, .rst_n,
        .start(clear_start),
        .gnt(clr_gnt),
        .req(clr_req),
        .wr(clr_wr),
        .done(clear_done)
    );

    rect_fill_drawer rect_fill_drawer_i (
        .clk_100m, .rst_n,
        .start(fill_start),
        .rect(fill_rect),
        .gnt(fill_gnt),
        .req(fill_req),
        .wr(fill_wr),
        .done(fill_done)
    );

    fb_arbiter fb_arbiter_i (
        .clk_100m, .rst_n,
        .rd_en, .rd_x, .rd_y,
        .clr_req, .clr_wr, .fill_req, .fill_wr,
        .clr_gnt, .fill_gnt,
        .mem_req, .rd_valid
    );

    fb_memory fb_memory_i (
        .clk_100m,
        .req(mem_req),
        .rd_cidx
    );

endmodule

`default_nettype wire

// ==== verilog/fb_clearer.sv ====
// framebuffer clearer
// writes the background index to every pixel, one per granted cycle
`timescale 1ns/1ps
`default_nettype none

`include "fb_bounce_consts.svh"

module fb_clearer (
    input  wire logic              clk_100m,
    input  wire logic              rst_n,
    input  wire logic              start,
    input  wire logic              gnt,
    output logic                   req,
    output fb_bounce_pkg::fb_req_t wr,
    output logic                   done
);

    localparam fb_bounce_pkg::coord_t x_last = fb_bounce_pkg::coord_t'(`FB_WIDTH - 1);
    localparam fb_bounce_pkg::coord_t y_last = fb_bounce_pkg::coord_t'(`FB_HEIGHT - 1);

    fb_bounce_pkg::coord_t x, y;

    assign wr = '{we: 1'b1, x: x, y: y, cidx: fb_bounce_pkg::cidx_t'(`FB_BG_IDX)};

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            req  <= 1'b0;
            done <= 1'b0;
            x    <= '0;
            y    <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                req <= 1'b1;
                x   <= '0;
                y   <= '0;
            end else if (req && gnt) begin  // pixel written this cycle
                if (x == x_last) begin
                    x <= '0;
                    if (y == y_last) begin
                        req  <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        y <= y + 1'b1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fb_memory.sv ====
// framebuffer memory
// single-port synchronous RAM of colour indices, addressed by x and y
`timescale 1ns/1ps
`default_nettype none

`include "fb_bounce_consts.svh"

module fb_memory (
    input  wire logic                   clk_100m,
    input  wire fb_bounce_pkg::fb_req_t req,
    output fb_bounce_pkg::cidx_t        rd_cidx
);

    localparam int depth = `FB_WIDTH * `FB_HEIGHT;
    localparam int addr_w = $clog2(depth);

    fb_bounce_pkg::cidx_t mem [depth];
    logic [addr_w-1:0] addr;

    assign addr = addr_w'(req.y * `FB_WIDTH + req.x);  // row major

    always_ff @(posedge clk_100m) begin
        if (req.we) mem[addr] <= req.cidx;
        else        rd_cidx   <= mem[addr];  // read data held during writes
    end

endmodule

`default_nettype wire

// ==== verilog/rect_fill_drawer.sv ====
// rectangle fill drawer
// writes the foreground index over a rectangle in row order
`timescale 1ns/1ps
`default_nettype none

`include "fb_bounce_consts.svh"

module rect_fill_drawer (
    input  wire logic                 clk_100m,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire fb_bounce_pkg::rect_t rect,
    input  wire logic                 gnt,
    output logic                      req,
    output fb_bounce_pkg::fb_req_t    wr,
    output logic                      done
);

    fb_bounce_pkg::coord_t x, y;
    fb_bounce_pkg::coord_t x0_q, x1_q, y1_q;  // latched bounds
    logic row_end, last_row;

    assign row_end  = (fb_bounce_pkg::coord_t'(x + 1'b1) == x1_q);
    assign last_row = (fb_bounce_pkg::coord_t'(y + 1'b1) == y1_q);

    assign wr = '{we: 1'b1, x: x, y: y, cidx: fb_bounce_pkg::cidx_t'(`FB_FG_IDX)};

    // rectangle bounds latched at start
    always_ff @(posedge clk_100m) begin
        if (start) begin
            x0_q <= rect.x0;
            x1_q <= rect.x1;
            y1_q <= rect.y1;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            req  <= 1'b0;
            done <= 1'b0;
            x    <= '0;
            y    <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                req <= 1'b1;
                x   <= rect.x0;
                y   <= rect.y0;
            end else if (req && gnt) begin
                if (row_end) begin
                    x <= x0_q;                // back to left side
                    if (last_row) begin
                        req  <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        y <= y + 1'b1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/square_animator.sv ====
// square animator
// steps the square once per frame strobe and bounces it off the buffer edges
`timescale 1ns/1ps
`default_nettype none

`include "fb_bounce_consts.svh"

module square_animator (
    input  wire logic             clk_100m,
    input  wire logic             rst_n,
    input  wire logic             frame,   // one pulse per frame
    output fb_bounce_pkg::sq_pos_t sq_pos
);

    localparam fb_bounce_pkg::coord_t speed = fb_bounce_pkg::coord_t'(`SQ_SPEED);
    localparam fb_bounce_pkg::coord_t x_lim =
        fb_bounce_pkg::coord_t'(`FB_WIDTH - (`SQ_SIZE + `SQ_SPEED));
    localparam fb_bounce_pkg::coord_t y_lim =
        fb_bounce_pkg::coord_t'(`FB_HEIGHT - (`SQ_SIZE + `SQ_SPEED));

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sq_pos <= '0;                          // top-left moving right and down
        end else if (frame) begin
            if (sq_pos.x >= x_lim) begin           // right edge
                sq_pos.dx <= 1'b1;
                sq_pos.x  <= sq_pos.x - speed;
            end else if (sq_pos.x < speed) begin   // left edge
                sq_pos.dx <= 1'b0;
                sq_pos.x  <= sq_pos.x + speed;
            end else begin
                sq_pos.x  <= sq_pos.dx ? sq_pos.x - speed : sq_pos.x + speed;
            end

            if (sq_pos.y >= y_lim) begin           // bottom edge
                sq_pos.dy <= 1'b1;
                sq_pos.y  <= sq_pos.y - speed;
            end else if (sq_pos.y < speed) begin   // top edge
                sq_pos.dy <= 1'b0;
                sq_pos.y  <= sq_pos.y + speed;
            end else begin
                sq_pos.y  <= sq_pos.dy ? sq_pos.y - speed : sq_pos.y + speed;
            end
        end
    end

endmodule

`default_nettype wire
